// ==== src/exec_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width and function-code settings for the execute unit.
// EXEC_XLEN is 64 or 32. At 32 the word flag has no effect.
// EXEC_SHW must equal log2 of EXEC_XLEN.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data path width.
`define EXEC_XLEN 64

// Shift amount width, log2 of the data width.
`define EXEC_SHW 6

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Function select codes, RISC-V funct3 order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define F3_ADDSUB 3'd0
`define F3_SLL 3'd1
`define F3_SLT 3'd2
`define F3_SLTU 3'd3
`define F3_XOR 3'd4
// Logical or arithmetic right shift, picked by ashr.
`define F3_SR 3'd5
`define F3_OR 3'd6
`define F3_AND 3'd7

`endif

// ==== src/exec_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the execute unit and its testbench.
// Widths follow exec_cfg.svh.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "exec_cfg.svh"

package exec_pkg;

   // One data word.
   typedef logic [`EXEC_XLEN-1:0] xword_t;

   // Shift amount or remaining count.
   typedef logic [`EXEC_SHW-1:0] shamt_t;

   // Function select.
   typedef enum logic [2:0] {
      f3_addsub = `F3_ADDSUB,
      f3_sll    = `F3_SLL,
      f3_slt    = `F3_SLT,
      f3_sltu   = `F3_SLTU,
      f3_xor    = `F3_XOR,
      f3_sr     = `F3_SR,
      f3_or     = `F3_OR,
      f3_and    = `F3_AND
   } funct3_t;

   // One issued operation.
   typedef struct packed {
      logic    sub;
      logic    ashr;
      logic    w;
      funct3_t funct3;
      xword_t  op1;
      xword_t  op2;
   } exec_req_t;

   // Sequencer states.
   typedef enum logic [1:0] {
      st_idle,
      st_alu,
      st_shift,
      st_done
   } exec_state_t;

   // Sign extension from bit 31; identity when XLEN is 32.
   function automatic xword_t sext_word(xword_t v);
      xword_t r;
      r = v;
      for (int i = 32; i < `EXEC_XLEN; i++) begin
         r[i] = v[31];
      end
      return r;
   endfunction

endpackage

// ==== src/alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational integer ALU, shifts excluded.
// Shift codes return zero; the shifter covers them.
// Compares always subtract, whatever sub says.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "exec_cfg.svh"

module alu
   import exec_pkg::*;
(
   input  exec_req_t req,
   output xword_t    result
);

   localparam int XLEN = `EXEC_XLEN;

   logic          is_cmp;
   logic          do_sub;
   logic [XLEN:0] opb;
   logic [XLEN:0] sum;
   logic          lt_signed;
   logic          lt_unsigned;
   xword_t        raw;

   // Compares need the difference.
   assign is_cmp = (req.funct3 == f3_slt) || (req.funct3 == f3_sltu);
   assign do_sub = req.sub | is_cmp;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Adder, one bit wider than the data.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Inverted op2 including the extra top bit.
   assign opb = {(XLEN+1){do_sub}} ^ {1'b0, req.op2};
   assign sum = {1'b0, req.op1} + opb + {{XLEN{1'b0}}, do_sub};

   // Top bit set means a borrow, so op1 < op2 unsigned.
   assign lt_unsigned = sum[XLEN];

   // Differing signs decide directly.
   // Equal signs cannot overflow, so the difference sign decides.
   assign lt_signed = (req.op1[XLEN-1] != req.op2[XLEN-1]) ?
                      req.op1[XLEN-1] : sum[XLEN-1];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Function select.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      case (req.funct3)
         f3_addsub: raw = sum[XLEN-1:0];
         f3_slt:    raw = {{(XLEN-1){1'b0}}, lt_signed};
         f3_sltu:   raw = {{(XLEN-1){1'b0}}, lt_unsigned};
         f3_xor:    raw = req.op1 ^ req.op2;
         f3_or:     raw = req.op1 | req.op2;
         f3_and:    raw = req.op1 & req.op2;
         // Shifts, never picked from here.
         default:   raw = '0;
      endcase
   end

   // Word ops keep the low half, sign-extended.
   assign result = req.w ? sext_word(raw) : raw;

endmodule

// ==== src/shift_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Down counter for the remaining shift steps.
// Stepping at zero is held off by the sequencer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module shift_counter
   import exec_pkg::*;
(
   input  logic   clock,
   input  logic   rst_n,
   input  logic   load,
   input  logic   step,
   input  logic   w,
   input  shamt_t shamt_src,
   output logic   zero
);

   shamt_t count;
   shamt_t load_val;

   // Word shifts use only 5 amount bits.
   assign load_val = w ? (shamt_src & shamt_t'(5'h1f)) : shamt_src;

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         count <= '0;
      end else if (load) begin
         count <= load_val;
      end else if (step) begin
         // One bit moved per step.
         count <= count - shamt_t'(1);
      end
   end

   // Zero amount means no steps at all.
   assign zero = (count == '0);

endmodule

// ==== src/shifter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial shifter, one bit per step.
// Step count comes from shift_counter.
// Word mode works on the low 32 bits and sign-extends them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "exec_cfg.svh"

module shifter
   import exec_pkg::*;
(
   input  logic      clock,
   input  logic      rst_n,
   input  logic      load,
   input  logic      step,
   input  exec_req_t req,
   output xword_t    value
);

   localparam int XLEN = `EXEC_XLEN;

   xword_t data;
   xword_t shr_next;
   logic   left;
   logic   fill;
   logic   w_q;
   logic   fill_src;

   // Arithmetic fill is the operand sign bit.
   // In word mode that is bit 31.
   assign fill_src = req.w ? (req.op1[31] & req.ashr) :
                            (req.op1[XLEN-1] & req.ashr);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Control state.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clock) begin
      if (!rst_n) begin
         left <= 1'b0;
         fill <= 1'b0;
         w_q  <= 1'b0;
      end else if (load) begin
         left <= (req.funct3 == f3_sll);
         fill <= fill_src;
         w_q  <= req.w;
      end
   end

   // Right shift by one.
   // Word mode enters the fill at bit 31.
   // Upper bits are don't care there.
   always_comb begin
      shr_next = {fill, data[XLEN-1:1]};
      if (w_q) begin
         shr_next[31] = fill;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Shift register.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clock) begin
      if (load) begin
         data <= req.op1;
      end else if (step) begin
         // Left shifts insert zero.
         data <= left ? {data[XLEN-2:0], 1'b0} : shr_next;
      end
   end

   // Word results repeat bit 31 upward.
   assign value = w_q ? sext_word(data) : data;

endmodule

// ==== src/exec_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencer for the execute unit.
// One operation at a time; a start while busy is dropped.
// Latency is 2 clocks for ALU ops, amount plus 3 for shifts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module exec_fsm
   import exec_pkg::*;
(
   input  logic    clock,
   input  logic    rst_n,
   input  logic    start,
   input  funct3_t funct3,
   input  logic    zero,
   output logic    accept,
   output logic    load,
   output logic    step,
   output logic    sel_shift,
   output logic    capture,
   output logic    busy,
   output logic    done
);

   exec_state_t state;
   exec_state_t state_nxt;
   logic        is_shift;
   logic        load_q;

   // Shift codes go the serial path.
   assign is_shift = (funct3 == f3_sll) || (funct3 == f3_sr);

   // Accept only from idle.
   assign accept = (state == st_idle) && start;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Next state.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (start) begin
               state_nxt = is_shift ? st_shift : st_alu;
            end
         end
         st_alu:   state_nxt = st_done;
         st_shift: begin
            // Leave once the count is spent.
            if (!load_q && zero) begin
               state_nxt = st_done;
            end
         end
         default:  state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         state  <= st_idle;
         load_q <= 1'b0;
      end else begin
         state  <= state_nxt;
         // Load follows the move to st_shift by one clock.
         load_q <= accept && is_shift;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Steering outputs.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign load      = load_q;
   // Zero flag is stale in the load cycle.
   assign step      = (state == st_shift) && !load_q && !zero;
   assign sel_shift = (state == st_shift);
   assign capture   = (state == st_alu) ||
                      ((state == st_shift) && !load_q && zero);
   assign busy      = (state != st_idle);
   assign done      = (state == st_done);

endmodule

// ==== src/exec_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute unit top: ALU plus a serial shifter.
// req is sampled only with an accepted start.
// result holds from done until the next done.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "exec_cfg.svh"

module exec_unit
   import exec_pkg::*;
(
   input  logic      clock,
   input  logic      rst_n,
   input  logic      start,
   input  exec_req_t req,
   output logic      busy,
   output logic      done,
   output xword_t    result
);

   exec_req_t req_q;
   logic      accept;
   logic      load;
   logic      step;
   logic      sel_shift;
   logic      capture;
   logic      zero;
   xword_t    alu_result;
   xword_t    shift_value;

   // Request register, loaded on accept.
   always_ff @(posedge clock) begin
      if (accept) begin
         req_q <= req;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Blocks.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Path choice uses the incoming code.
   exec_fsm fsm_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .start     (start),
      .funct3    (req.funct3),
      .zero      (zero),
      .accept    (accept),
      .load      (load),
      .step      (step),
      .sel_shift (sel_shift),
      .capture   (capture),
      .busy      (busy),
      .done      (done)
   );

   // Amount is the low bits of op2.
   shift_counter counter_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .load      (load),
      .step      (step),
      .w         (req_q.w),
      .shamt_src (req_q.op2[`EXEC_SHW-1:0]),
      .zero      (zero)
   );

   shifter shifter_i (
      .clock (clock),
      .rst_n (rst_n),
      .load  (load),
      .step  (step),
      .req   (req_q),
      .value (shift_value)
   );

   alu alu_i (
      .req    (req_q),
      .result (alu_result)
   );

   // Result register.
   always_ff @(posedge clock) begin
      if (!rst_n) begin
         result <= '0;
      end else if (capture) begin
         result <= sel_shift ? shift_value : alu_result;
      end
   end

endmodule

// ==== tb/exec_ref.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected results and latencies for exec_unit operations.
// Include inside a module that imports exec_pkg.
// Needs exec_cfg.svh included first.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Low 32 bits, sign-extended to the data width.
function automatic xword_t word_extend(input xword_t v);
   logic signed [31:0] lo;
   xword_t             r;
   lo = v[31:0];
   // Signed source widens with its sign.
   r = lo;
   return r;
endfunction

// Amount from op2; word mode keeps 5 bits.
function automatic int shift_amount(input exec_req_t r);
   if (r.w) begin
      return int'(r.op2[4:0]);
   end
   return int'(r.op2[`EXEC_SHW-1:0]);
endfunction

function automatic xword_t expected_result(input exec_req_t r);
   xword_t                        v;
   logic signed [`EXEC_XLEN-1:0] s;
   logic [31:0]                   lo;
   logic signed [31:0]            lo_s;
   int                            n;
   n = shift_amount(r);
   v = '0;
   lo = r.op1[31:0];
   case (r.funct3)
      f3_addsub: v = r.sub ? (r.op1 - r.op2) : (r.op1 + r.op2);
      f3_slt:    v[0] = ($signed(r.op1) < $signed(r.op2));
      f3_sltu:   v[0] = (r.op1 < r.op2);
      f3_xor:    v = r.op1 ^ r.op2;
      f3_or:     v = r.op1 | r.op2;
      f3_and:    v = r.op1 & r.op2;
      f3_sll: begin
         if (r.w) begin
            lo = lo << n;
            v[31:0] = lo;
         end else begin
            v = r.op1 << n;
         end
      end
      default: begin
         // Right shifts, fill chosen by ashr.
         if (r.w) begin
            lo_s = lo;
            lo_s = lo_s >>> n;
            lo = r.ashr ? lo_s : (lo >> n);
            v[31:0] = lo;
         end else begin
            s = r.op1;
            s = s >>> n;
            v = r.ashr ? s : (r.op1 >> n);
         end
      end
   endcase
   if (r.w) begin
      v = word_extend(v);
   end
   return v;
endfunction

// Clocks from the start edge to done.
function automatic int expected_latency(input exec_req_t r);
   if ((r.funct3 == f3_sll) || (r.funct3 == f3_sr)) begin
      return shift_amount(r) + 3;
   end
   return 2;
endfunction

`endif

// ==== tb/exec_unit_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for exec_unit, one op at a time.
// Odd rows pulse start again while busy; it must be dropped.
// XLEN must be a multiple of 32.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "exec_cfg.svh"

module exec_unit_tb
   import exec_pkg::*;
();

   `include "exec_ref.svh"

   localparam int     XLEN     = `EXEC_XLEN;
   localparam int     NUM_ROWS = 64;
   localparam int     MAX_WAIT = 80;
   localparam int     PERIOD   = 100;
   localparam xword_t XMIN     = {1'b1, {(XLEN-1){1'b0}}};
   localparam xword_t XMAX     = ~XMIN;
   localparam xword_t ONES     = '1;

   // One table row, expected columns filled at build time.
   typedef struct packed {
      exec_req_t  req;
      xword_t     exp_value;
      logic [7:0] latency;
   } row_t;

   logic        clock;
   logic        rst_n;
   logic        start;
   exec_req_t   req;
   logic        busy;
   logic        done;
   xword_t      result;
   row_t        rows[$];
   int          value_errors;
   int          timing_errors;
   int          control_errors;
   int unsigned seed_val;

   exec_unit exec_unit_i (
      .clock  (clock),
      .rst_n  (rst_n),
      .start  (start),
      .req    (req),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   initial begin
      clock = 1'b0;
      forever #(PERIOD/2) clock = ~clock;
   end

   // Watchdog, sized for the longest shift on every row.
   initial begin
      #((NUM_ROWS * MAX_WAIT + 16) * PERIOD);
      $display("Timeout: run did not finish within %0d clocks", NUM_ROWS * MAX_WAIT + 16);
      $display("Test FAILED");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus table.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic xword_t random_word();
      xword_t v;
      for (int k = 0; k < XLEN; k += 32) begin
         v[k +: 32] = $urandom;
      end
      return v;
   endfunction

   function automatic exec_req_t random_req();
      exec_req_t r;
      r.funct3 = funct3_t'($urandom_range(7));
      r.sub    = $urandom_range(1);
      r.ashr   = $urandom_range(1);
      r.w      = $urandom_range(1);
      r.op1    = random_word();
      r.op2    = random_word();
      return r;
   endfunction

   function automatic void add_row(input funct3_t f, input logic sub, input logic ashr,
                                   input logic w, input xword_t a, input xword_t b);
      row_t row;
      row.req.funct3 = f;
      row.req.sub    = sub;
      row.req.ashr   = ashr;
      row.req.w      = w;
      row.req.op1    = a;
      row.req.op2    = b;
      row.exp_value  = expected_result(row.req);
      row.latency    = 8'(expected_latency(row.req));
      rows.push_back(row);
   endfunction

   function automatic void build_table();
      row_t row;
      // Carry wrap both ways.
      add_row(f3_addsub, 1'b0, 1'b0, 1'b0, XMAX, 1);
      add_row(f3_addsub, 1'b0, 1'b0, 1'b0, ONES, 1);
      add_row(f3_addsub, 1'b1, 1'b0, 1'b0, '0, 1);
      add_row(f3_addsub, 1'b1, 1'b0, 1'b0, XMIN, 1);
      // Word overflow.
      add_row(f3_addsub, 1'b0, 1'b0, 1'b1, 32'h7fffffff, 1);
      add_row(f3_addsub, 1'b1, 1'b0, 1'b1, 32'h80000000, 1);
      // Most negative value in both compares.
      add_row(f3_slt, 1'b0, 1'b0, 1'b0, XMIN, '0);
      add_row(f3_sltu, 1'b0, 1'b0, 1'b0, XMIN, '0);
      add_row(f3_slt, 1'b0, 1'b0, 1'b0, '0, XMIN);
      add_row(f3_sltu, 1'b0, 1'b0, 1'b0, '0, XMIN);
      add_row(f3_slt, 1'b0, 1'b0, 1'b0, XMIN, XMAX);
      add_row(f3_sltu, 1'b1, 1'b0, 1'b0, XMIN, XMIN);
      // Logic ops, word xor too.
      add_row(f3_xor, 1'b0, 1'b0, 1'b0, {(XLEN/16){16'hf0f0}}, {(XLEN/16){16'hff00}});
      add_row(f3_or, 1'b0, 1'b0, 1'b0, {(XLEN/16){16'hf0f0}}, {(XLEN/16){16'h0ff0}});
      add_row(f3_and, 1'b1, 1'b0, 1'b0, {(XLEN/16){16'hf0f0}}, {(XLEN/16){16'h3c3c}});
      add_row(f3_xor, 1'b0, 1'b0, 1'b1, '0, 32'h80000001);
      // Shifts by zero and by XLEN-1.
      add_row(f3_sll, 1'b0, 1'b0, 1'b0, ONES, '0);
      add_row(f3_sll, 1'b0, 1'b0, 1'b0, 1, XLEN - 1);
      add_row(f3_sr, 1'b0, 1'b0, 1'b0, XMIN, '0);
      add_row(f3_sr, 1'b0, 1'b0, 1'b0, XMIN, XLEN - 1);
      add_row(f3_sr, 1'b0, 1'b1, 1'b0, XMIN, XLEN - 1);
      add_row(f3_sr, 1'b0, 1'b1, 1'b0, XMAX, XLEN - 1);
      // Word shifts; 63 wraps to 31.
      add_row(f3_sll, 1'b0, 1'b0, 1'b1, 1, 31);
      add_row(f3_sr, 1'b0, 1'b0, 1'b1, 32'h80000000, 31);
      add_row(f3_sr, 1'b0, 1'b1, 1'b1, 32'h80000000, 63);
      add_row(f3_sr, 1'b0, 1'b0, 1'b1, ONES ^ xword_t'(32'h80000000), '0);
      while (rows.size() < NUM_ROWS) begin
         row.req = random_req();
         add_row(row.req.funct3, row.req.sub, row.req.ashr, row.req.w,
                 row.req.op1, row.req.op2);
      end
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // One operation, entered and left on a falling edge.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic run_row(input int idx, input row_t row);
      exec_req_t noise;
      xword_t    held;
      int        cycles;
      noise = random_req();
      req = row.req;
      start = 1'b1;
      cycles = 0;
      do begin
         @(negedge clock);
         cycles++;
         // Request changes after acceptance; odd rows restart while busy.
         if (cycles == 1) begin
            start = (idx % 2 == 1);
            req = noise;
         end else begin
            start = 1'b0;
         end
         if (!busy) begin
            control_errors++;
            $display("Row %0d: busy low at %0t before done", idx, $time);
         end
      end while (!done && cycles < MAX_WAIT);
      if (!done) begin
         timing_errors++;
         $display("Row %0d: done never arrived within %0d clocks", idx, MAX_WAIT);
      end else begin
         if (cycles != int'(row.latency)) begin
            timing_errors++;
            $display("Fail at %0t: done latency = %0d, expected %0d (row %0d)",
                     $time, cycles, row.latency, idx);
         end
         if (result !== row.exp_value) begin
            value_errors++;
            $display("Fail at %0t: result = %h, expected %h (row %0d)",
                     $time, result, row.exp_value, idx);
         end
         held = result;
         @(negedge clock);
         // A dropped start leaves the unit idle.
         if (done || busy) begin
            control_errors++;
            $display("Row %0d: done or busy still high one clock after done", idx);
         end
         if (result !== held) begin
            value_errors++;
            $display("Fail at %0t: result = %h, expected %h (row %0d, held)",
                     $time, result, held, idx);
         end
      end
   endtask

   initial begin
      seed_val = $urandom(32'h7f20);
      rst_n = 1'b0;
      start = 1'b0;
      req = '0;
      value_errors = 0;
      timing_errors = 0;
      control_errors = 0;
      build_table();
      repeat (16) @(posedge clock);
      @(negedge clock);
      rst_n = 1'b1;
      // Reset state.
      if (busy || done) begin
         control_errors++;
         $display("busy or done high after reset");
      end
      if (result !== '0) begin
         value_errors++;
         $display("Fail at %0t: result = %h, expected %h", $time, result, xword_t'(0));
      end
      for (int i = 0; i < rows.size(); i++) begin
         run_row(i, rows[i]);
      end
      $display("Errors: value %0d, timing %0d, control %0d",
               value_errors, timing_errors, control_errors);
      if (value_errors + timing_errors + control_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+src
+incdir+tb
src/exec_pkg.sv
src/alu.sv
src/shift_counter.sv
src/shifter.sv
src/exec_fsm.sv
src/exec_unit.sv
tb/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/exec_pkg.sv
      - src/alu.sv
      - src/shift_counter.sv
      - src/shifter.sv
      - src/exec_fsm.sv
      - src/exec_unit.sv
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/exec_unit_tb.sv
